// ==== common/cpu_pkg.sv ====
// cpu back end shared definitions
package cpu_pkg;

    // datapath and register file
    localparam int xlen         = 32;
    localparam int reg_addr_w   = 5;
    localparam int reg_count    = 1 << reg_addr_w;

    // word addressing, low two address bits select a byte
    localparam int word_addr_w  = xlen - 2;

    // data cache geometry and miss timing
    localparam int dcache_depth = 256;
    localparam int depth_w      = $clog2(dcache_depth);
    localparam int line_words   = 4;
    localparam int line_off_w   = $clog2(line_words);
    localparam int tag_w        = word_addr_w - line_off_w;
    localparam int miss_cycles  = 3;
    localparam int miss_cnt_w   = $clog2(miss_cycles + 1);

    typedef logic [miss_cnt_w-1:0] miss_cnt_t;

    // counter value loaded on the first stall cycle of a miss
    localparam miss_cnt_t miss_reload = miss_cnt_t'(miss_cycles - 1);

    typedef enum logic [3:0] {
        add    = 4'd0,
        sub    = 4'd1,
        and_op = 4'd2,
        or_op  = 4'd3,
        xor_op = 4'd4,
        addi   = 4'd5,
        load   = 4'd6,
        store  = 4'd7,
        nop    = 4'd8
    } opcode_e;

    typedef struct packed {
        logic                  valid;
        opcode_e               op;
        logic [reg_addr_w-1:0] rs1;
        logic [reg_addr_w-1:0] rs2;
        logic [reg_addr_w-1:0] rd;
        logic [xlen-1:0]       imm;
        logic [xlen-1:0]       pc_plus_4;
    } issue_t;

    typedef struct packed {
        logic [xlen-1:0]       alu_result;
        logic [xlen-1:0]       mem_wdata;
        logic                  memrd;
        logic                  memwr;
        logic [xlen-1:0]       pc_plus_4;
        logic [reg_addr_w-1:0] rd;
        logic                  mem2reg;
        logic                  regwr;
    } ex_mem_t;

    typedef struct packed {
        logic [xlen-1:0]       alu_result;
        logic [xlen-1:0]       mem_dat;
        logic [xlen-1:0]       pc_plus_4;
        logic [reg_addr_w-1:0] rd;
        logic                  mem2reg;
        logic                  regwr;
    } mem_wb_t;

    typedef struct packed {
        logic                   ren;
        logic                   wen;
        logic [word_addr_w-1:0] addr;
        logic [xlen-1:0]        wdata;
    } dcache_req_t;

    // reverses byte order, same mapping in both directions
    function automatic logic [xlen-1:0] byte_swap(input logic [xlen-1:0] word);
        logic [xlen-1:0] swapped;
        for (int i = 0; i < xlen / 8; i++) begin
            swapped[8*i +: 8] = word[xlen-8-8*i +: 8];
        end
        return swapped;
    endfunction

endpackage

// ==== ex/ex_stage.sv ====
// execute stage
module ex_stage (
    input  logic                             clk,
    input  logic                             rst_n,
    input  cpu_pkg::issue_t                  issue,
    input  logic                             stall,
    input  logic [cpu_pkg::xlen-1:0]         rs1_data,
    input  logic [cpu_pkg::xlen-1:0]         rs2_data,
    output logic [cpu_pkg::reg_addr_w-1:0]   rs1_idx,
    output logic [cpu_pkg::reg_addr_w-1:0]   rs2_idx,
    output cpu_pkg::ex_mem_t                 ex_mem
);

    cpu_pkg::ex_mem_t          ex_mem_next;
    logic [cpu_pkg::xlen-1:0]  alu_result;
    logic [cpu_pkg::xlen-1:0]  imm_sum;
    logic                      active;

    // register file read happens in the issue cycle
    assign rs1_idx = issue.rs1;
    assign rs2_idx = issue.rs2;

    // invalid slots and nops turn into bubbles
    assign active  = issue.valid && (issue.op != cpu_pkg::nop);

    // shared adder for addi and effective addresses
    assign imm_sum = rs1_data + issue.imm;

    always_comb begin
        case (issue.op)
            cpu_pkg::add:    alu_result = rs1_data + rs2_data;
            cpu_pkg::sub:    alu_result = rs1_data - rs2_data;
            cpu_pkg::and_op: alu_result = rs1_data & rs2_data;
            cpu_pkg::or_op:  alu_result = rs1_data | rs2_data;
            cpu_pkg::xor_op: alu_result = rs1_data ^ rs2_data;
            cpu_pkg::addi,
            cpu_pkg::load,
            cpu_pkg::store:  alu_result = imm_sum;
            default:         alu_result = '0;
        endcase
    end

    always_comb begin
        ex_mem_next            = '0;
        ex_mem_next.alu_result = alu_result;
        ex_mem_next.mem_wdata  = rs2_data;
        ex_mem_next.pc_plus_4  = issue.pc_plus_4;
        ex_mem_next.rd         = issue.rd;
        if (active) begin
            ex_mem_next.memrd   = (issue.op == cpu_pkg::load);
            ex_mem_next.memwr   = (issue.op == cpu_pkg::store);
            ex_mem_next.mem2reg = (issue.op == cpu_pkg::load);
            // every active op except store writes a register
            ex_mem_next.regwr   = (issue.op != cpu_pkg::store);
        end
    end

    // EX/MEM register, frozen while the cache stalls
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ex_mem <= '0;
        end else if (!stall) begin
            ex_mem <= ex_mem_next;
        end
    end

    // the cache port carries one access per instruction
    a_single_access: assert property (
        @(posedge clk) disable iff (!rst_n)
        !(ex_mem.memrd && ex_mem.memwr)
    );

endmodule

// ==== mem/mem_stage.sv ====
// memory stage
module mem_stage (
    input  logic                       clk,
    input  logic                       rst_n,
    input  cpu_pkg::ex_mem_t           ex_mem,
    input  logic                       stall,
    input  logic [cpu_pkg::xlen-1:0]   rdata,
    output cpu_pkg::dcache_req_t       dcache_req,
    output cpu_pkg::mem_wb_t           mem_wb
);

    // cache request straight from EX/MEM, no register in between
    always_comb begin
        dcache_req.ren   = ex_mem.memrd;
        dcache_req.wen   = ex_mem.memwr;
        // word address, byte offset dropped
        dcache_req.addr  = ex_mem.alu_result[cpu_pkg::xlen-1:2];
        // memory keeps the opposite byte order
        dcache_req.wdata = cpu_pkg::byte_swap(ex_mem.mem_wdata);
    end

    // MEM/WB register
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mem_wb <= '0;
        end else begin
            // read data is sampled every cycle, back in core order
            mem_wb.mem_dat <= cpu_pkg::byte_swap(rdata);
            if (!stall) begin
                mem_wb.alu_result <= ex_mem.alu_result;
                mem_wb.pc_plus_4  <= ex_mem.pc_plus_4;
                mem_wb.rd         <= ex_mem.rd;
                mem_wb.mem2reg    <= ex_mem.mem2reg;
                mem_wb.regwr      <= ex_mem.regwr;
            end
        end
    end

    // relies on the cache holding rdata during a miss
    a_hold_on_stall: assert property (
        @(posedge clk) disable iff (!rst_n)
        stall |=> $stable(mem_wb)
    );

endmodule

// ==== mem/dcache.sv ====
// data cache model
module dcache (
    input  logic                       clk,
    input  logic                       rst_n,
    input  cpu_pkg::dcache_req_t       req,
    output logic [cpu_pkg::xlen-1:0]   rdata,
    output logic                       stall
);

    logic [cpu_pkg::xlen-1:0]     mem_q [cpu_pkg::dcache_depth];
    logic [cpu_pkg::tag_w-1:0]    open_tag;
    logic                         open_valid;
    cpu_pkg::miss_cnt_t           miss_cnt;
    logic [cpu_pkg::xlen-1:0]     rdata_hold;
    logic [cpu_pkg::tag_w-1:0]    req_tag;
    logic [cpu_pkg::depth_w-1:0]  req_idx;
    logic                         access;
    logic                         hit;

    assign req_tag = req.addr[cpu_pkg::word_addr_w-1:cpu_pkg::line_off_w];
    assign req_idx = req.addr[cpu_pkg::depth_w-1:0];
    assign access  = req.ren || req.wen;
    assign hit     = open_valid && (open_tag == req_tag);

    // stall until the miss counter has run down on the new line
    assign stall   = access && (!hit || (miss_cnt != '0));

    // the last delivered word stays on rdata through a miss
    assign rdata   = stall ? rdata_hold : mem_q[req_idx];

    // open line and miss timing
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            open_valid <= 1'b0;
            open_tag   <= '0;
            miss_cnt   <= '0;
        end else if (access && !hit) begin
            open_valid <= 1'b1;
            open_tag   <= req_tag;
            miss_cnt   <= cpu_pkg::miss_reload;
        end else if (miss_cnt != '0) begin
            miss_cnt   <= miss_cnt - 1'b1;
        end
    end

    // word array, writes land on the cycle stall drops
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < cpu_pkg::dcache_depth; i++) begin
                mem_q[i] <= '0;
            end
            rdata_hold <= '0;
        end else begin
            if (!stall) begin
                rdata_hold <= mem_q[req_idx];
            end
            if (req.wen && !stall) begin
                mem_q[req_idx] <= req.wdata;
            end
        end
    end

    // a miss never lasts longer than its fixed penalty
    a_stall_bounded: assert property (
        @(posedge clk) disable iff (!rst_n)
        stall [*cpu_pkg::miss_cycles] |=> !stall
    );

endmodule

// ==== wb/wb_stage.sv ====
// writeback stage and register file
module wb_stage (
    input  logic                             clk,
    input  logic                             rst_n,
    input  cpu_pkg::mem_wb_t                 mem_wb,
    input  logic [cpu_pkg::reg_addr_w-1:0]   rs1_idx,
    input  logic [cpu_pkg::reg_addr_w-1:0]   rs2_idx,
    output logic [cpu_pkg::xlen-1:0]         rs1_data,
    output logic [cpu_pkg::xlen-1:0]         rs2_data,
    output logic                             retire_en,
    output logic [cpu_pkg::reg_addr_w-1:0]   retire_rd,
    output logic [cpu_pkg::xlen-1:0]         retire_data
);

    logic [cpu_pkg::xlen-1:0]  regs [cpu_pkg::reg_count];
    logic [cpu_pkg::xlen-1:0]  wb_data;
    logic                      wr_en;

    // loads take memory data, everything else the ALU result
    assign wb_data     = mem_wb.mem2reg ? mem_wb.mem_dat : mem_wb.alu_result;

    // bubbles arrive with regwr low
    assign retire_en   = mem_wb.regwr;
    assign retire_rd   = mem_wb.rd;
    assign retire_data = wb_data;

    // x0 is hardwired
    assign wr_en       = mem_wb.regwr && (mem_wb.rd != '0);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < cpu_pkg::reg_count; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en) begin
            regs[mem_wb.rd] <= wb_data;
        end
    end

    // two asynchronous read ports
    always_comb begin
        rs1_data = (rs1_idx == '0) ? '0 : regs[rs1_idx];
        rs2_data = (rs2_idx == '0) ? '0 : regs[rs2_idx];
    end

endmodule

// ==== design/mem_subsys_top.sv ====
// pipeline back end top
module mem_subsys_top (
    input  logic                             clk,
    input  logic                             rst_n,
    input  cpu_pkg::issue_t                  issue,
    output logic                             stall,
    output logic                             retire_en,
    output logic [cpu_pkg::reg_addr_w-1:0]   retire_rd,
    output logic [cpu_pkg::xlen-1:0]         retire_data
);

    cpu_pkg::ex_mem_t                ex_mem;
    cpu_pkg::mem_wb_t                mem_wb;
    cpu_pkg::dcache_req_t            dcache_req;
    logic [cpu_pkg::xlen-1:0]        rdata;
    logic [cpu_pkg::reg_addr_w-1:0]  rs1_idx;
    logic [cpu_pkg::reg_addr_w-1:0]  rs2_idx;
    logic [cpu_pkg::xlen-1:0]        rs1_data;
    logic [cpu_pkg::xlen-1:0]        rs2_data;

    ex_stage u_ex (
        .clk      (clk),
        .rst_n    (rst_n),
        .issue    (issue),
        .stall    (stall),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .rs1_idx  (rs1_idx),
        .rs2_idx  (rs2_idx),
        .ex_mem   (ex_mem)
    );

    mem_stage u_mem (
        .clk        (clk),
        .rst_n      (rst_n),
        .ex_mem     (ex_mem),
        .stall      (stall),
        .rdata      (rdata),
        .dcache_req (dcache_req),
        .mem_wb     (mem_wb)
    );

    // stall level fans out to both pipeline registers
    dcache u_dcache (
        .clk   (clk),
        .rst_n (rst_n),
        .req   (dcache_req),
        .rdata (rdata),
        .stall (stall)
    );

    wb_stage u_wb (
        .clk         (clk),
        .rst_n       (rst_n),
        .mem_wb      (mem_wb),
        .rs1_idx     (rs1_idx),
        .rs2_idx     (rs2_idx),
        .rs1_data    (rs1_data),
        .rs2_data    (rs2_data),
        .retire_en   (retire_en),
        .retire_rd   (retire_rd),
        .retire_data (retire_data)
    );

endmodule

// ==== tb/tb_tests.svh ====
// directed tests for the back end

localparam logic [31:0] line_a      = 32'h300;
localparam logic [31:0] line_b      = 32'h340;
localparam logic [31:0] line_c      = 32'h3c0;
localparam logic [31:0] stream_line = 32'h380;

// sources come from x1..x8, never written by the stream
function automatic int pick_src();
    return int'($urandom_range(1, 8));
endfunction

function automatic logic [31:0] word_in_line(input logic [31:0] base);
    return base + (32'($urandom_range(0, cpu_pkg::line_words - 1)) << 2);
endfunction

task automatic test_alu();
    cpu_pkg::opcode_e op;
    for (int r = 1; r <= preload_count; r++) begin
        issue_instr(make_instr(cpu_pkg::addi, r, 0, 0, $urandom()));
        drain_pipeline();
    end
    for (int i = 0; i < alu_rand_count; i++) begin
        op = cpu_pkg::opcode_e'($urandom_range(0, 5));
        issue_instr(make_instr(op, int'($urandom_range(1, 31)), int'($urandom_range(0, 31)),
                               int'($urandom_range(0, 31)), $urandom()));
        drain_pipeline();
    end
endtask

task automatic test_store_load();
    logic [31:0] addr;
    logic [31:0] data;
    for (int i = 0; i < mem_pairs; i++) begin
        addr = 32'($urandom_range(0, cpu_pkg::dcache_depth - 1)) << 2;
        data = $urandom();
        issue_instr(make_instr(cpu_pkg::addi, 10, 0, 0, data));
        drain_pipeline();
        // load right behind the store
        issue_instr(make_instr(cpu_pkg::store, 0, 0, 10, addr));
        issue_instr(make_instr(cpu_pkg::load, 11, 0, 0, addr));
        drain_pipeline();
    end
endtask

task automatic test_miss_stall();
    int          stall_base;
    logic [31:0] base;
    // open an unrelated line so the first load below misses too
    issue_instr(make_instr(cpu_pkg::load, 30, 0, 0, line_c));
    drain_pipeline();
    stall_base = stall_cycles;
    for (int i = 0; i < miss_pairs; i++) begin
        base = (i % 2 == 0) ? line_a : line_b;
        issue_instr(make_instr(cpu_pkg::xor_op, 20 + i, pick_src(), pick_src(), '0));
        issue_instr(make_instr(cpu_pkg::load, 26, 0, 0, word_in_line(base)));
    end
    drain_pipeline();
    compare_values("stall_cycles", miss_pairs * cpu_pkg::miss_cycles, stall_cycles - stall_base);
endtask

task automatic test_zero_and_bubbles();
    cpu_pkg::issue_t ins;
    logic [31:0]     zaddr;
    zaddr = 32'($urandom_range(0, cpu_pkg::dcache_depth - 1)) << 2;
    issue_instr(make_instr(cpu_pkg::addi, 0, 0, 0, $urandom()));
    drain_pipeline();
    issue_instr(make_instr(cpu_pkg::add, 12, 0, 0, '0));
    ins       = make_instr(cpu_pkg::store, 0, 0, 5, zaddr);
    ins.valid = 1'b0;
    issue_instr(ins);
    issue_instr(make_instr(cpu_pkg::nop, 3, 1, 2, $urandom()));
    ins       = make_instr(cpu_pkg::addi, 14, 0, 0, $urandom());
    ins.valid = 1'b0;
    issue_instr(ins);
    drain_pipeline();
    // memory and x14 must be untouched by the bubbles
    issue_instr(make_instr(cpu_pkg::load, 13, 0, 0, zaddr));
    issue_instr(make_instr(cpu_pkg::or_op, 15, 14, 0, '0));
    drain_pipeline();
endtask

task automatic test_stream();
    cpu_pkg::opcode_e op;
    int               stall_base;
    // open the stream line so only hits follow
    issue_instr(make_instr(cpu_pkg::load, 9, 0, 0, stream_line));
    drain_pipeline();
    stall_base = stall_cycles;
    for (int i = 0; i < stream_count; i++) begin
        op = cpu_pkg::opcode_e'($urandom_range(0, 7));
        case (op)
            cpu_pkg::load: begin
                issue_instr(make_instr(op, int'($urandom_range(9, 31)), 0, 0,
                                       word_in_line(stream_line)));
            end
            cpu_pkg::store: begin
                issue_instr(make_instr(op, 0, 0, pick_src(), word_in_line(stream_line)));
            end
            default: begin
                issue_instr(make_instr(op, int'($urandom_range(9, 31)), pick_src(),
                                       pick_src(), $urandom()));
            end
        endcase
    end
    drain_pipeline();
    // accesses inside the open line never stall
    compare_values("stall_cycles", 0, stall_cycles - stall_base);
endtask

// ==== tb/tb_top.sv ====
// pipeline back end testbench
module tb_top;

    localparam int preload_count  = 8;
    localparam int alu_rand_count = 16;
    localparam int mem_pairs      = 16;
    localparam int miss_pairs     = 6;
    localparam int zero_count     = 7;
    localparam int stream_count   = 40;
    localparam int total_instr    = preload_count + alu_rand_count + 3 * mem_pairs
                                    + 1 + 2 * miss_pairs + zero_count + 1 + stream_count;
    // cycles between a producer and its dependent instruction
    localparam int spacing_cycles = 4;
    localparam int reset_cycles   = 10;
    localparam int timeout_cycles = total_instr * (2 + cpu_pkg::miss_cycles + spacing_cycles)
                                    + reset_cycles + 200;

    typedef struct packed {
        logic [cpu_pkg::reg_addr_w-1:0] rd;
        logic [cpu_pkg::xlen-1:0]       data;
    } retire_t;

    logic                            clk;
    logic                            rst_n;
    cpu_pkg::issue_t                 issue;
    logic                            stall;
    logic                            retire_en;
    logic [cpu_pkg::reg_addr_w-1:0]  retire_rd;
    logic [cpu_pkg::xlen-1:0]        retire_data;

    // reference model state, updated in program order
    logic [cpu_pkg::xlen-1:0]        model_regs [cpu_pkg::reg_count];
    logic [cpu_pkg::xlen-1:0]        model_mem [cpu_pkg::dcache_depth];
    retire_t                         exp_q [$];
    logic [cpu_pkg::xlen-1:0]        pc;
    int                              stall_cycles;

    // retire outputs seen at the previous falling edge
    logic                            prev_stall;
    logic                            snap_en;
    logic [cpu_pkg::reg_addr_w-1:0]  snap_rd;
    logic [cpu_pkg::xlen-1:0]        snap_data;

    mem_subsys_top i_dut (
        .clk         (clk),
        .rst_n       (rst_n),
        .issue       (issue),
        .stall       (stall),
        .retire_en   (retire_en),
        .retire_rd   (retire_rd),
        .retire_data (retire_data)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Something failed");
        $fatal(1);
    endtask

    task automatic compare_values(input string name, input logic [31:0] expected,
                                  input logic [31:0] actual);
        if (expected !== actual) begin
            abort_run($sformatf("FAIL %s expected %h actual %h", name, expected, actual));
        end
    endtask

    function automatic logic [31:0] model_alu(input cpu_pkg::opcode_e op,
                                              input logic [31:0] a, input logic [31:0] b,
                                              input logic [31:0] imm);
        case (op)
            cpu_pkg::add:    return a + b;
            cpu_pkg::sub:    return a - b;
            cpu_pkg::and_op: return a & b;
            cpu_pkg::or_op:  return a | b;
            cpu_pkg::xor_op: return a ^ b;
            cpu_pkg::addi:   return a + imm;
            default:         return '0;
        endcase
    endfunction

    function automatic cpu_pkg::issue_t make_instr(input cpu_pkg::opcode_e op, input int rd,
                                                   input int rs1, input int rs2,
                                                   input logic [31:0] imm);
        cpu_pkg::issue_t ins;
        ins       = '0;
        ins.valid = 1'b1;
        ins.op    = op;
        ins.rd    = cpu_pkg::reg_addr_w'(rd);
        ins.rs1   = cpu_pkg::reg_addr_w'(rs1);
        ins.rs2   = cpu_pkg::reg_addr_w'(rs2);
        ins.imm   = imm;
        return ins;
    endfunction

    function automatic cpu_pkg::issue_t idle_instr();
        cpu_pkg::issue_t ins;
        ins       = make_instr(cpu_pkg::nop, 0, 0, 0, '0);
        ins.valid = 1'b0;
        return ins;
    endfunction

    task automatic record_expected(input cpu_pkg::issue_t ins);
        logic [31:0]                  a;
        logic [31:0]                  b;
        logic [31:0]                  ea;
        logic [cpu_pkg::depth_w-1:0]  widx;
        retire_t                      exp;
        if (ins.valid && ins.op != cpu_pkg::nop) begin
            a    = model_regs[ins.rs1];
            b    = model_regs[ins.rs2];
            ea   = a + ins.imm;
            widx = ea[cpu_pkg::depth_w+1:2];
            if (ins.op == cpu_pkg::store) begin
                model_mem[widx] = b;
            end else begin
                exp.rd   = ins.rd;
                exp.data = (ins.op == cpu_pkg::load) ? model_mem[widx]
                                                     : model_alu(ins.op, a, b, ins.imm);
                exp_q.push_back(exp);
                if (ins.rd != '0) begin
                    model_regs[ins.rd] = exp.data;
                end
            end
        end
    endtask

    // called on a falling edge, returns on the falling edge after acceptance
    task automatic issue_instr(input cpu_pkg::issue_t ins);
        cpu_pkg::issue_t cur;
        cur           = ins;
        cur.pc_plus_4 = pc + 4;
        pc            = pc + 4;
        issue         = cur;
        // held steady until the cache lets the pipeline move
        while (stall) begin
            @(negedge clk);
        end
        record_expected(cur);
        @(negedge clk);
        issue = idle_instr();
    endtask

    task automatic drain_pipeline();
        while (exp_q.size() != 0) begin
            @(negedge clk);
        end
        // register file write lands on the next rising edge
        @(negedge clk);
    endtask

    // retire monitor, one retirement per edge where the pipeline moves
    always @(negedge clk) begin : retire_monitor
        retire_t got;
        if (rst_n) begin
            if (prev_stall) begin
                compare_values("retire_en", 32'(snap_en), 32'(retire_en));
                compare_values("retire_rd", 32'(snap_rd), 32'(retire_rd));
                compare_values("retire_data", snap_data, retire_data);
            end
            if (stall) begin
                stall_cycles++;
            end
            if (retire_en && !stall) begin
                if (exp_q.size() == 0) begin
                    abort_run("retire_en went high with no instruction expected");
                end else begin
                    got = exp_q.pop_front();
                    compare_values("retire_rd", 32'(got.rd), 32'(retire_rd));
                    compare_values("retire_data", got.data, retire_data);
                end
            end
            prev_stall = stall;
            snap_en    = retire_en;
            snap_rd    = retire_rd;
            snap_data  = retire_data;
        end
    end

    initial begin
        repeat (timeout_cycles) @(posedge clk);
        abort_run("watchdog expired before the tests finished");
    end

    `include "tb_tests.svh"

    initial begin
        void'($urandom(32'h9f69_6610));
        rst_n         = 1'b0;
        issue         = idle_instr();
        pc            = '0;
        stall_cycles  = 0;
        prev_stall    = 1'b0;
        for (int i = 0; i < cpu_pkg::reg_count; i++) begin
            model_regs[i] = '0;
        end
        for (int i = 0; i < cpu_pkg::dcache_depth; i++) begin
            model_mem[i] = '0;
        end
        repeat (reset_cycles) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);
        test_alu();
        test_store_load();
        test_miss_stall();
        test_zero_and_bubbles();
        test_stream();
        drain_pipeline();
        $display("Everything OK");
        $finish;
    end

endmodule

// ==== tb.f ====
+incdir+tb
common/cpu_pkg.sv
ex/ex_stage.sv
mem/mem_stage.sv
mem/dcache.sv
wb/wb_stage.sv
design/mem_subsys_top.sv
tb/tb_top.sv

// ==== Bender.yml ====
package:
  name: mem_subsys

sources:
  - common/cpu_pkg.sv
  - ex/ex_stage.sv
  - mem/mem_stage.sv
  - mem/dcache.sv
  - wb/wb_stage.sv
  - design/mem_subsys_top.sv
  - target: simulation
    include_dirs:
      - tb
    files:
      - tb/tb_top.sv
